// ==== list.f ====
+incdir+design
design/rv_pkg.sv
design/idu.sv
design/regfile.sv
design/alu.sv
design/pipe_reg.sv
design/rv_exec_slice.sv
sim/tb_rv_exec_slice.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it from the project root.

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ps -f list.f \
   --top-module tb_rv_exec_slice -Mdir obj_dir -o tb_sim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "Verification passed" sim.log; then
   exit 0
fi
echo "pass message not found in sim.log"
exit 1

// ==== sim/tb_rv_exec_slice.sv ====
`timescale 1ns/1ps
`include "rv_consts.svh"

module tb_rv_exec_slice;

   typedef enum logic [1:0] {
      KIND_WB,
      KIND_BR,
      KIND_MEM,
      KIND_NONE
   } kind_e;

   typedef struct packed {
      logic [`XLEN-1:0]   pc;
      logic [`INSN_W-1:0] insn;
      logic               b2b;
      kind_e              kind;
      logic               we;
      logic [`REG_AW-1:0] rd;
      logic [`XLEN-1:0]   value;
      logic               taken;
      logic [`XLEN-1:0]   addr;
      logic               load;
      logic               store;
      logic [3:0]         size;
      logic               sign;
   } entry_t;

   logic               i_clk = 1'b0;
   logic               i_reset;
   logic               i_valid;
   logic [`INSN_W-1:0] i_insn;
   logic [`XLEN-1:0]   i_pc;
   logic               o_wb_valid;
   logic               o_wb_we;
   logic [`REG_AW-1:0] o_wb_rd;
   logic [`XLEN-1:0]   o_wb_data;
   logic               o_br_taken;
   logic [`XLEN-1:0]   o_br_target;
   logic               o_mem_load;
   logic               o_mem_store;
   logic [`XLEN-1:0]   o_mem_addr;
   logic [3:0]         o_mem_size;
   logic               o_mem_sigext;
   logic [`XLEN-1:0]   o_mem_wdata;

   entry_t tbl [$];
   entry_t exp_q [$];
   entry_t cur;
   int     n_entries = 0;
   int     n_checked = 0;

   rv_exec_slice uut (
      .i_clk        (i_clk),
      .i_reset      (i_reset),
      .i_valid      (i_valid),
      .i_insn       (i_insn),
      .i_pc         (i_pc),
      .o_wb_valid   (o_wb_valid),
      .o_wb_we      (o_wb_we),
      .o_wb_rd      (o_wb_rd),
      .o_wb_data    (o_wb_data),
      .o_br_taken   (o_br_taken),
      .o_br_target  (o_br_target),
      .o_mem_load   (o_mem_load),
      .o_mem_store  (o_mem_store),
      .o_mem_addr   (o_mem_addr),
      .o_mem_size   (o_mem_size),
      .o_mem_sigext (o_mem_sigext),
      .o_mem_wdata  (o_mem_wdata)
   );

   always #5 i_clk = ~i_clk;

   function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
      return {imm[11:5], rs2, rs1, f3, imm[4:0], `OPC_STORE};
   endfunction

   function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
      return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `OPC_BRANCH};
   endfunction

   function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
      return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `OPC_JAL};
   endfunction

   // entries sit at consecutive word addresses starting at 0x1000.
   function automatic entry_t blank_entry(input logic [31:0] insn, input logic b2b);
      entry_t e;
      e = '0;
      e.pc = 64'h1000 + 64'(tbl.size() * 4);
      e.insn = insn;
      e.b2b = b2b;
      e.kind = KIND_NONE;
      return e;
   endfunction

   task automatic add_wb(input logic [31:0] insn, input logic b2b, input logic [4:0] rd,
                         input logic [63:0] value);
      entry_t e;
      e = blank_entry(insn, b2b);
      e.kind = KIND_WB;
      e.we = 1'b1;
      e.rd = rd;
      e.value = value;
      tbl.push_back(e);
   endtask

   task automatic add_br(input logic [31:0] insn, input logic we, input logic [4:0] rd,
                         input logic [63:0] value, input logic taken, input logic [63:0] target);
      entry_t e;
      e = blank_entry(insn, 1'b0);
      e.kind = KIND_BR;
      e.we = we;
      e.rd = rd;
      e.value = value;
      e.taken = taken;
      e.addr = target;
      tbl.push_back(e);
   endtask

   task automatic add_mem(input logic [31:0] insn, input logic store, input logic [63:0] addr,
                          input logic [3:0] size, input logic sign, input logic [63:0] wdata);
      entry_t e;
      e = blank_entry(insn, 1'b0);
      e.kind = KIND_MEM;
      e.load = ~store;
      e.store = store;
      e.addr = addr;
      e.size = size;
      e.sign = sign;
      e.value = wdata;
      tbl.push_back(e);
   endtask

   // no entry reads the register written by the entry right before it.
   task automatic build_table();
      add_wb({12'd100, 5'd0, 3'b000, 5'd1, `OPC_OPIMM}, 0, 5'd1, 64'h64);
      add_wb({12'hff8, 5'd0, 3'b000, 5'd2, `OPC_OPIMM}, 0, 5'd2, 64'hffff_ffff_ffff_fff8);
      add_wb({12'd101, 5'd1, 3'b011, 5'd3, `OPC_OPIMM}, 0, 5'd3, 64'h1);
      add_wb({20'h80000, 5'd4, `OPC_LUI}, 0, 5'd4, 64'hffff_ffff_8000_0000);
      add_wb({20'h12345, 5'd5, `OPC_AUIPC}, 0, 5'd5, 64'h1234_6010);
      add_wb({`F7_ALT, 5'd2, 5'd1, 3'b000, 5'd6, `OPC_OP}, 0, 5'd6, 64'h6c);
      add_wb({`F7_ALT, 5'd1, 5'd2, 3'b101, 5'd7, `OPC_OP}, 0, 5'd7, 64'hffff_ffff_ffff_ffff);
      add_wb({7'h00, 5'd1, 5'd2, 3'b010, 5'd8, `OPC_OP}, 0, 5'd8, 64'h1);
      add_wb({7'h00, 5'd1, 5'd4, 3'b000, 5'd9, `OPC_OP32}, 0, 5'd9, 64'hffff_ffff_8000_0064);
      add_wb({7'h00, 5'd25, 5'd1, 3'b001, 5'd10, `OPC_OPIMM32}, 0, 5'd10,
             64'hffff_ffff_c800_0000);
      add_wb({`F7_ALT, 5'd1, 5'd4, 3'b101, 5'd11, `OPC_OP32}, 0, 5'd11,
             64'hffff_ffff_f800_0000);
      // x12 reaches the ADD two slots later through the writeback bypass.
      add_wb({12'h7ff, 5'd0, 3'b000, 5'd12, `OPC_OPIMM}, 0, 5'd12, 64'h7ff);
      add_wb({12'd1, 5'd0, 3'b000, 5'd13, `OPC_OPIMM}, 1, 5'd13, 64'h1);
      add_wb({7'h00, 5'd12, 5'd12, 3'b000, 5'd14, `OPC_OP}, 1, 5'd14, 64'hffe);
      add_wb({12'd1, 5'd12, 3'b000, 5'd15, `OPC_OPIMM}, 0, 5'd15, 64'h800);
      // the x0 write must not be bypassed into the ADD that reads x0.
      add_wb({12'd55, 5'd1, 3'b000, 5'd0, `OPC_OPIMM}, 0, 5'd0, 64'h9b);
      add_wb({12'd3, 5'd0, 3'b000, 5'd17, `OPC_OPIMM}, 1, 5'd17, 64'h3);
      add_wb({7'h00, 5'd1, 5'd0, 3'b000, 5'd16, `OPC_OP}, 1, 5'd16, 64'h64);
      add_br(enc_b(13'd16, 5'd6, 5'd1, 3'b000), 0, 5'd0, 64'h0, 0, 64'h1058);
      add_br(enc_b(13'h1ff8, 5'd6, 5'd1, 3'b001), 0, 5'd0, 64'h0, 1, 64'h1044);
      add_br(enc_b(13'd32, 5'd1, 5'd2, 3'b100), 0, 5'd0, 64'h0, 1, 64'h1070);
      add_br(enc_b(13'd32, 5'd1, 5'd2, 3'b110), 0, 5'd0, 64'h0, 0, 64'h1074);
      add_br(enc_b(13'h1f00, 5'd1, 5'd2, 3'b111), 0, 5'd0, 64'h0, 1, 64'h0f58);
      add_br(enc_b(13'd64, 5'd1, 5'd2, 3'b101), 0, 5'd0, 64'h0, 0, 64'h109c);
      add_br(enc_j(21'd2048, 5'd18), 1, 5'd18, 64'h1064, 1, 64'h1860);
      add_br({12'd7, 5'd1, 3'b000, 5'd19, `OPC_JALR}, 1, 5'd19, 64'h1068, 1, 64'h6a);
      add_mem({12'hffc, 5'd1, 3'b010, 5'd20, `OPC_LOAD}, 0, 64'h60, 4'd4, 1, 64'h0);
      add_mem({12'd8, 5'd2, 3'b100, 5'd21, `OPC_LOAD}, 0, 64'h0, 4'd1, 0, 64'h0);
      add_mem(enc_s(12'd16, 5'd4, 5'd1, 3'b011), 1, 64'h74, 4'd8, 0, 64'hffff_ffff_8000_0000);
      add_mem(enc_s(12'hffe, 5'd12, 5'd15, 3'b001), 1, 64'h7fe, 4'd2, 0, 64'h7ff);
      add_mem({12'd0, 5'd5, 3'b011, 5'd22, `OPC_LOAD}, 0, 64'h1234_6010, 4'd8, 0, 64'h0);
      tbl.push_back(blank_entry(32'hffff_ffff, 1'b0));
      tbl.push_back(blank_entry({7'h01, 5'd1, 5'd1, 3'b000, 5'd25, `OPC_OP}, 1'b0));
      add_wb({7'h00, 5'd14, 5'd15, 3'b000, 5'd23, `OPC_OP}, 0, 5'd23, 64'h17fe);
      add_wb({7'h00, 5'd0, 5'd25, 3'b000, 5'd24, `OPC_OP}, 0, 5'd24, 64'h0);
   endtask

   task automatic report_mismatch(input string name, input logic [63:0] exp_val,
                                  input logic [63:0] act_val);
      $display("ERROR at %0t ns: %s expected %0h, got %0h", $time, name, exp_val, act_val);
      $display("Verification failed");
      $fatal(1, "mismatch on %s", name);
   endtask

   task automatic check_wb(input logic exp_we, input logic [`REG_AW-1:0] exp_rd,
                           input logic [`XLEN-1:0] exp_data);
      if (o_wb_we !== exp_we)
         report_mismatch("o_wb_we", 64'(exp_we), 64'(o_wb_we));
      if (exp_we && o_wb_rd !== exp_rd)
         report_mismatch("o_wb_rd", 64'(exp_rd), 64'(o_wb_rd));
      if (exp_we && o_wb_data !== exp_data)
         report_mismatch("o_wb_data", exp_data, o_wb_data);
   endtask

   task automatic check_br(input logic exp_taken, input logic [`XLEN-1:0] exp_target,
                           input logic cmp_target);
      if (o_br_taken !== exp_taken)
         report_mismatch("o_br_taken", 64'(exp_taken), 64'(o_br_taken));
      if (cmp_target && o_br_target !== exp_target)
         report_mismatch("o_br_target", exp_target, o_br_target);
   endtask

   task automatic check_mem(input logic exp_load, input logic exp_store,
                            input logic [`XLEN-1:0] exp_addr, input logic [3:0] exp_size,
                            input logic exp_sign, input logic [`XLEN-1:0] exp_wdata);
      if (o_mem_load !== exp_load)
         report_mismatch("o_mem_load", 64'(exp_load), 64'(o_mem_load));
      if (o_mem_store !== exp_store)
         report_mismatch("o_mem_store", 64'(exp_store), 64'(o_mem_store));
      if ((exp_load || exp_store) && o_mem_addr !== exp_addr)
         report_mismatch("o_mem_addr", exp_addr, o_mem_addr);
      if ((exp_load || exp_store) && o_mem_size !== exp_size)
         report_mismatch("o_mem_size", 64'(exp_size), 64'(o_mem_size));
      if ((exp_load || exp_store) && o_mem_sigext !== exp_sign)
         report_mismatch("o_mem_sigext", 64'(exp_sign), 64'(o_mem_sigext));
      if (exp_store && o_mem_wdata !== exp_wdata)
         report_mismatch("o_mem_wdata", exp_wdata, o_mem_wdata);
   endtask

   // outputs settle after the rising edge, so they are sampled on the falling edge.
   always @(negedge i_clk) begin
      if (!i_reset && o_wb_valid) begin
         if (exp_q.size() == 0) begin
            $display("o_wb_valid pulsed at %0t ns with no instruction left to retire", $time);
            $display("Verification failed");
            $fatal(1, "extra writeback");
         end else begin
            cur = exp_q.pop_front();
            check_wb(cur.we, cur.rd, cur.value);
            check_br(cur.taken, cur.addr, cur.kind == KIND_BR);
            check_mem(cur.load, cur.store, cur.addr, cur.size, cur.sign, cur.value);
            n_checked++;
         end
      end
   end

   initial begin
      #1;
      #((n_entries * 5 + 20) * 10);
      $display("timeout with %0d instructions still waiting for writeback", exp_q.size());
      $display("Verification failed");
      $fatal(1, "watchdog expired");
   end

   initial begin
      int gap;
      void'($urandom(32'h23e7));
      i_reset = 1'b1;
      i_valid = 1'b0;
      i_insn = '0;
      i_pc = '0;
      build_table();
      n_entries = tbl.size();
      repeat (3) @(posedge i_clk);
      i_reset <= 1'b0;
      for (int k = 0; k < n_entries; k++) begin
         if (k > 0 && !tbl[k].b2b) begin
            gap = $urandom % 3;
            repeat (gap) begin
               @(posedge i_clk);
               i_valid <= 1'b0;
            end
         end
         @(posedge i_clk);
         i_valid <= 1'b1;
         i_insn <= tbl[k].insn;
         i_pc <= tbl[k].pc;
         exp_q.push_back(tbl[k]);
      end
      @(posedge i_clk);
      i_valid <= 1'b0;
      // the last instruction retires two edges later, and the quiet cycles after it
      // expose any writeback beyond the last entry.
      repeat (6) @(posedge i_clk);
      if (n_checked != n_entries) begin
         $display("saw %0d writebacks for %0d instructions", n_checked, n_entries);
         $display("Verification failed");
         $fatal(1, "writeback count mismatch");
      end else begin
         $display("Verification passed");
         $finish;
      end
   end

endmodule

// ==== design/rv_exec_slice.sv ====
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_exec_slice (
   input  logic               i_clk,
   input  logic               i_reset,
   input  logic               i_valid,
   input  logic [`INSN_W-1:0] i_insn,
   input  logic [`XLEN-1:0]   i_pc,
   output logic               o_wb_valid,
   output logic               o_wb_we,
   output logic [`REG_AW-1:0] o_wb_rd,
   output logic [`XLEN-1:0]   o_wb_data,
   output logic               o_br_taken,
   output logic [`XLEN-1:0]   o_br_target,
   output logic               o_mem_load,
   output logic               o_mem_store,
   output logic [`XLEN-1:0]   o_mem_addr,
   output logic [3:0]         o_mem_size,
   output logic               o_mem_sigext,
   output logic [`XLEN-1:0]   o_mem_wdata
);

   rv_pkg::ex_payload_t ex_d;
   rv_pkg::ex_payload_t ex_q;
   rv_pkg::wb_payload_t wb_d;
   rv_pkg::wb_payload_t wb_q;
   logic                ex_valid;
   logic                wb_valid;
   logic [`REG_AW-1:0]  rs1_addr;
   logic [`REG_AW-1:0]  rs2_addr;

   idu u_idu (
      .i_insn       (i_insn),
      .i_valid      (i_valid),
      .o_rs1_addr   (rs1_addr),
      .o_rs2_addr   (rs2_addr),
      .o_alu_op     (ex_d.alu_op),
      .o_word       (ex_d.word),
      .o_opb_sel    (ex_d.opb_sel),
      .o_imm        (ex_d.imm),
      .o_rd         (ex_d.rd),
      .o_rf_we      (ex_d.rf_we),
      .o_mem_load   (ex_d.mem_load),
      .o_mem_store  (ex_d.mem_store),
      .o_mem_size   (ex_d.mem_size),
      .o_mem_sigext (ex_d.mem_sigext)
   );

   regfile u_regfile (
      .i_clk      (i_clk),
      .i_reset    (i_reset),
      .i_rs1_addr (rs1_addr),
      .i_rs2_addr (rs2_addr),
      .o_rs1_data (ex_d.rs1_data),
      .o_rs2_data (ex_d.rs2_data),
      .i_we       (o_wb_we),
      .i_wr_addr  (wb_q.rd),
      .i_wr_data  (wb_q.result)
   );

   assign ex_d.pc = i_pc;

   pipe_reg #(.T(rv_pkg::ex_payload_t)) u_ex_reg (
      .i_clk   (i_clk),
      .i_reset (i_reset),
      .i_valid (i_valid),
      .i_data  (ex_d),
      .o_valid (ex_valid),
      .o_data  (ex_q)
   );

   alu u_alu (
      .i_alu_op    (ex_q.alu_op),
      .i_word      (ex_q.word),
      .i_opb_sel   (ex_q.opb_sel),
      .i_imm       (ex_q.imm),
      .i_pc        (ex_q.pc),
      .i_rs1       (ex_q.rs1_data),
      .i_rs2       (ex_q.rs2_data),
      .o_result    (wb_d.result),
      .o_br_taken  (wb_d.br_taken),
      .o_br_target (wb_d.br_target),
      .o_mem_addr  (wb_d.mem_addr)
   );

   assign wb_d.rd         = ex_q.rd;
   assign wb_d.rf_we      = ex_q.rf_we;
   assign wb_d.mem_load   = ex_q.mem_load;
   assign wb_d.mem_store  = ex_q.mem_store;
   assign wb_d.mem_size   = ex_q.mem_size;
   assign wb_d.mem_sigext = ex_q.mem_sigext;
   assign wb_d.mem_wdata  = ex_q.rs2_data;

   pipe_reg #(.T(rv_pkg::wb_payload_t)) u_wb_reg (
      .i_clk   (i_clk),
      .i_reset (i_reset),
      .i_valid (ex_valid),
      .i_data  (wb_d),
      .o_valid (wb_valid),
      .o_data  (wb_q)
   );

   // the payload is stale in a bubble, so the strobes are qualified by the stage valid.
   assign o_wb_valid   = wb_valid;
   assign o_wb_we      = wb_valid & wb_q.rf_we;
   assign o_wb_rd      = wb_q.rd;
   assign o_wb_data    = wb_q.result;
   assign o_br_taken   = wb_valid & wb_q.br_taken;
   assign o_br_target  = wb_q.br_target;
   assign o_mem_load   = wb_valid & wb_q.mem_load;
   assign o_mem_store  = wb_valid & wb_q.mem_store;
   assign o_mem_addr   = wb_q.mem_addr;
   assign o_mem_size   = wb_q.mem_size;
   assign o_mem_sigext = wb_q.mem_sigext;
   assign o_mem_wdata  = wb_q.mem_wdata;

   // an accepted instruction reaches writeback exactly two edges later.
   assert property (@(posedge i_clk) disable iff (i_reset) i_valid |-> ##2 o_wb_valid);

endmodule

// ==== design/pipe_reg.sv ====
`timescale 1ns/1ps

module pipe_reg #(
   parameter type T = logic
) (
   input  logic i_clk,
   input  logic i_reset,
   input  logic i_valid,
   input  T     i_data,
   output logic o_valid,
   output T     o_data
);

   always_ff @(posedge i_clk) begin
      if (i_reset) begin
         o_valid <= 1'b0;
      end else begin
         o_valid <= i_valid;
      end
   end

   // a bubble leaves the previous payload in place.
   always_ff @(posedge i_clk) begin
      if (i_valid) begin
         o_data <= i_data;
      end
   end

endmodule

// ==== design/alu.sv ====
`timescale 1ns/1ps
`include "rv_consts.svh"

module alu (
   input  rv_pkg::alu_op_e  i_alu_op,
   input  logic             i_word,
   input  rv_pkg::opb_sel_e i_opb_sel,
   input  logic [`XLEN-1:0] i_imm,
   input  logic [`XLEN-1:0] i_pc,
   input  logic [`XLEN-1:0] i_rs1,
   input  logic [`XLEN-1:0] i_rs2,
   output logic [`XLEN-1:0] o_result,
   output logic             o_br_taken,
   output logic [`XLEN-1:0] o_br_target,
   output logic [`XLEN-1:0] o_mem_addr
);

   logic [`XLEN-1:0] opb;
   logic [`XLEN-1:0] sum;
   logic [`XLEN-1:0] pc_imm;
   logic [`XLEN-1:0] srl_src;
   logic [`XLEN-1:0] sra_src;
   logic [`XLEN-1:0] raw;
   logic [5:0]       shamt;
   logic             eq;
   logic             lt;
   logic             ltu;

   assign opb    = (i_opb_sel == rv_pkg::OPB_RS2) ? i_rs2 : i_imm;
   assign sum    = i_rs1 + opb;
   assign pc_imm = i_pc + i_imm;
   assign eq     = (i_rs1 == opb);
   assign lt     = ($signed(i_rs1) < $signed(opb));
   assign ltu    = (i_rs1 < opb);

   // word shifts see only the low half of rs1, extended the way the shift needs.
   assign shamt   = i_word ? {1'b0, opb[4:0]} : opb[5:0];
   assign srl_src = i_word ? {32'b0, i_rs1[31:0]} : i_rs1;
   assign sra_src = i_word ? {{32{i_rs1[31]}}, i_rs1[31:0]} : i_rs1;

   always_comb begin
      case (i_alu_op)
         rv_pkg::ALU_ADD:   raw = sum;
         rv_pkg::ALU_SUB:   raw = i_rs1 - opb;
         rv_pkg::ALU_SLL:   raw = i_rs1 << shamt;
         rv_pkg::ALU_SLT:   raw = {{(`XLEN-1){1'b0}}, lt};
         rv_pkg::ALU_SLTU:  raw = {{(`XLEN-1){1'b0}}, ltu};
         rv_pkg::ALU_XOR:   raw = i_rs1 ^ opb;
         rv_pkg::ALU_SRL:   raw = srl_src >> shamt;
         rv_pkg::ALU_SRA:   raw = $signed(sra_src) >>> shamt;
         rv_pkg::ALU_OR:    raw = i_rs1 | opb;
         rv_pkg::ALU_AND:   raw = i_rs1 & opb;
         rv_pkg::ALU_LUI:   raw = i_imm;
         rv_pkg::ALU_AUIPC: raw = pc_imm;
         rv_pkg::ALU_JAL,
         rv_pkg::ALU_JALR:  raw = i_pc + `XLEN'(4);
         default:           raw = '0;
      endcase
   end

   assign o_result = i_word ? {{32{raw[31]}}, raw[31:0]} : raw;

   always_comb begin
      case (i_alu_op)
         rv_pkg::ALU_BEQ:   o_br_taken = eq;
         rv_pkg::ALU_BNE:   o_br_taken = ~eq;
         rv_pkg::ALU_BLT:   o_br_taken = lt;
         rv_pkg::ALU_BGE:   o_br_taken = ~lt;
         rv_pkg::ALU_BLTU:  o_br_taken = ltu;
         rv_pkg::ALU_BGEU:  o_br_taken = ~ltu;
         rv_pkg::ALU_JAL,
         rv_pkg::ALU_JALR:  o_br_taken = 1'b1;
         default:           o_br_taken = 1'b0;
      endcase
   end

   assign o_br_target = (i_alu_op == rv_pkg::ALU_JALR) ? {sum[`XLEN-1:1], 1'b0} : pc_imm;
   assign o_mem_addr  = sum;

endmodule

// ==== design/regfile.sv ====
`timescale 1ns/1ps
`include "rv_consts.svh"

module regfile (
   input  logic               i_clk,
   input  logic               i_reset,
   input  logic [`REG_AW-1:0] i_rs1_addr,
   input  logic [`REG_AW-1:0] i_rs2_addr,
   output logic [`XLEN-1:0]   o_rs1_data,
   output logic [`XLEN-1:0]   o_rs2_data,
   input  logic               i_we,
   input  logic [`REG_AW-1:0] i_wr_addr,
   input  logic [`XLEN-1:0]   i_wr_data
);

   logic [`XLEN-1:0] regs [`NUM_REGS];
   logic             wr_live;

   // x0 is never written, so it keeps the zero from reset.
   assign wr_live = i_we && (i_wr_addr != '0);

   always_ff @(posedge i_clk) begin
      if (i_reset) begin
         for (int i = 0; i < `NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_live) begin
         regs[i_wr_addr] <= i_wr_data;
      end
   end

   // a read of the register being written sees the new value.
   assign o_rs1_data = (wr_live && i_wr_addr == i_rs1_addr) ? i_wr_data : regs[i_rs1_addr];
   assign o_rs2_data = (wr_live && i_wr_addr == i_rs2_addr) ? i_wr_data : regs[i_rs2_addr];

   assert property (@(posedge i_clk) disable iff (i_reset)
      (i_rs1_addr == '0) |-> (o_rs1_data == '0));
   assert property (@(posedge i_clk) disable iff (i_reset)
      (i_rs2_addr == '0) |-> (o_rs2_data == '0));

endmodule

// ==== design/idu.sv ====
`timescale 1ns/1ps
`include "rv_consts.svh"

module idu (
   input  logic [`INSN_W-1:0] i_insn,
   input  logic               i_valid,
   output logic [`REG_AW-1:0] o_rs1_addr,
   output logic [`REG_AW-1:0] o_rs2_addr,
   output rv_pkg::alu_op_e    o_alu_op,
   output logic               o_word,
   output rv_pkg::opb_sel_e   o_opb_sel,
   output logic [`XLEN-1:0]   o_imm,
   output logic [`REG_AW-1:0] o_rd,
   output logic               o_rf_we,
   output logic               o_mem_load,
   output logic               o_mem_store,
   output logic [3:0]         o_mem_size,
   output logic               o_mem_sigext
);

   logic [6:0]       opcode;
   logic [2:0]       funct3;
   logic [6:0]       funct7;
   logic [`XLEN-1:0] imm_i;
   logic [`XLEN-1:0] imm_s;
   logic [`XLEN-1:0] imm_b;
   logic [`XLEN-1:0] imm_u;
   logic [`XLEN-1:0] imm_j;
   logic [`XLEN-1:0] imm_sh;
   logic             r_ok;
   logic             sh64_ok;
   logic             shw_ok;
   logic             wr;

   // funct3 to operation for register and immediate arithmetic.
   function automatic rv_pkg::alu_op_e arith_op(input logic [2:0] f3, input logic alt);
      case (f3)
         3'b000:  arith_op = alt ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
         3'b001:  arith_op = rv_pkg::ALU_SLL;
         3'b010:  arith_op = rv_pkg::ALU_SLT;
         3'b011:  arith_op = rv_pkg::ALU_SLTU;
         3'b100:  arith_op = rv_pkg::ALU_XOR;
         3'b101:  arith_op = alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
         3'b110:  arith_op = rv_pkg::ALU_OR;
         default: arith_op = rv_pkg::ALU_AND;
      endcase
   endfunction

   assign opcode     = i_insn[6:0];
   assign funct3     = i_insn[14:12];
   assign funct7     = i_insn[31:25];
   assign o_rd       = i_insn[11:7];
   assign o_rs1_addr = i_insn[19:15];
   assign o_rs2_addr = i_insn[24:20];

   assign imm_i  = {{52{i_insn[31]}}, i_insn[31:20]};
   assign imm_s  = {{52{i_insn[31]}}, i_insn[31:25], i_insn[11:7]};
   assign imm_b  = {{52{i_insn[31]}}, i_insn[7], i_insn[30:25], i_insn[11:8], 1'b0};
   assign imm_u  = {{32{i_insn[31]}}, i_insn[31:12], 12'b0};
   assign imm_j  = {{44{i_insn[31]}}, i_insn[19:12], i_insn[20], i_insn[30:21], 1'b0};
   assign imm_sh = {58'b0, i_insn[25:20]};

   // only SUB and SRA may carry the alternate funct7.
   assign r_ok    = (funct7 == 7'b0) ||
                    (funct7 == `F7_ALT && (funct3 == 3'b000 || funct3 == 3'b101));
   // 64-bit immediate shifts use funct6, since bit 25 belongs to the shift amount.
   assign sh64_ok = (i_insn[31:26] == 6'b0) ||
                    (funct3 == 3'b101 && {i_insn[31:26], 1'b0} == `F7_ALT);
   assign shw_ok  = (funct7 == 7'b0) || (funct3 == 3'b101 && funct7 == `F7_ALT);

   always_comb begin
      o_alu_op     = rv_pkg::ALU_NOP;
      o_word       = 1'b0;
      o_opb_sel    = rv_pkg::OPB_IMM;
      o_imm        = imm_i;
      o_mem_load   = 1'b0;
      o_mem_store  = 1'b0;
      o_mem_size   = 4'd0;
      o_mem_sigext = 1'b0;
      wr           = 1'b0;
      if (i_valid) begin
         case (opcode)
            `OPC_LUI, `OPC_AUIPC: begin
               o_alu_op = (opcode == `OPC_LUI) ? rv_pkg::ALU_LUI : rv_pkg::ALU_AUIPC;
               o_imm    = imm_u;
               wr       = 1'b1;
            end
            `OPC_JAL: begin
               o_alu_op = rv_pkg::ALU_JAL;
               o_imm    = imm_j;
               wr       = 1'b1;
            end
            `OPC_JALR: begin
               if (funct3 == 3'b000) begin
                  o_alu_op = rv_pkg::ALU_JALR;
                  wr       = 1'b1;
               end
            end
            `OPC_BRANCH: begin
               o_opb_sel = rv_pkg::OPB_RS2;
               o_imm     = imm_b;
               case (funct3)
                  3'b000:  o_alu_op = rv_pkg::ALU_BEQ;
                  3'b001:  o_alu_op = rv_pkg::ALU_BNE;
                  3'b100:  o_alu_op = rv_pkg::ALU_BLT;
                  3'b101:  o_alu_op = rv_pkg::ALU_BGE;
                  3'b110:  o_alu_op = rv_pkg::ALU_BLTU;
                  3'b111:  o_alu_op = rv_pkg::ALU_BGEU;
                  default: o_alu_op = rv_pkg::ALU_NOP;
               endcase
            end
            `OPC_LOAD: begin
               // the ALU only forms the address, nothing is written back here.
               if (funct3 != 3'b111) begin
                  o_alu_op     = rv_pkg::ALU_ADD;
                  o_mem_load   = 1'b1;
                  o_mem_size   = 4'd1 << funct3[1:0];
                  o_mem_sigext = ~funct3[2] & (funct3[1:0] != 2'b11);
               end
            end
            `OPC_STORE: begin
               if (!funct3[2]) begin
                  o_alu_op    = rv_pkg::ALU_ADD;
                  o_imm       = imm_s;
                  o_mem_store = 1'b1;
                  o_mem_size  = 4'd1 << funct3[1:0];
               end
            end
            `OPC_OPIMM: begin
               if (funct3 == 3'b001 || funct3 == 3'b101) begin
                  if (sh64_ok) begin
                     o_alu_op = arith_op(funct3, i_insn[30]);
                     o_imm    = imm_sh;
                     wr       = 1'b1;
                  end
               end else begin
                  o_alu_op = arith_op(funct3, 1'b0);
                  wr       = 1'b1;
               end
            end
            `OPC_OPIMM32: begin
               o_word = 1'b1;
               if (funct3 == 3'b000) begin
                  o_alu_op = rv_pkg::ALU_ADD;
                  wr       = 1'b1;
               end else if ((funct3 == 3'b001 || funct3 == 3'b101) && shw_ok) begin
                  o_alu_op = arith_op(funct3, funct7[5]);
                  o_imm    = imm_sh;
                  wr       = 1'b1;
               end
            end
            `OPC_OP, `OPC_OP32: begin
               o_opb_sel = rv_pkg::OPB_RS2;
               o_word    = (opcode == `OPC_OP32);
               if (r_ok && (opcode == `OPC_OP || funct3 == 3'b000 ||
                            funct3 == 3'b001 || funct3 == 3'b101)) begin
                  o_alu_op = arith_op(funct3, funct7[5]);
                  wr       = 1'b1;
               end
            end
            default: o_alu_op = rv_pkg::ALU_NOP;
         endcase
      end
      o_rf_we = wr;
   end

   always_comb begin
      assert (!(o_mem_load && o_mem_store));
      assert (!o_rf_we || o_alu_op != rv_pkg::ALU_NOP);
   end

endmodule

// ==== design/rv_pkg.sv ====
`include "rv_consts.svh"

package rv_pkg;

   typedef enum logic [4:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_SLL,
      ALU_SLT,
      ALU_SLTU,
      ALU_XOR,
      ALU_SRL,
      ALU_SRA,
      ALU_OR,
      ALU_AND,
      ALU_LUI,
      ALU_AUIPC,
      ALU_JAL,
      ALU_JALR,
      ALU_BEQ,
      ALU_BNE,
      ALU_BLT,
      ALU_BGE,
      ALU_BLTU,
      ALU_BGEU,
      ALU_NOP
   } alu_op_e;

   typedef enum logic {
      OPB_RS2,
      OPB_IMM
   } opb_sel_e;

   // decode to execute.
   typedef struct packed {
      alu_op_e            alu_op;
      logic               word;
      opb_sel_e           opb_sel;
      logic [`XLEN-1:0]   imm;
      logic [`XLEN-1:0]   pc;
      logic [`XLEN-1:0]   rs1_data;
      logic [`XLEN-1:0]   rs2_data;
      logic [`REG_AW-1:0] rd;
      logic               rf_we;
      logic               mem_load;
      logic               mem_store;
      logic [3:0]         mem_size;
      logic               mem_sigext;
   } ex_payload_t;

   // execute to writeback.
   typedef struct packed {
      logic [`REG_AW-1:0] rd;
      logic               rf_we;
      logic [`XLEN-1:0]   result;
      logic               br_taken;
      logic [`XLEN-1:0]   br_target;
      logic               mem_load;
      logic               mem_store;
      logic [`XLEN-1:0]   mem_addr;
      logic [3:0]         mem_size;
      logic               mem_sigext;
      logic [`XLEN-1:0]   mem_wdata;
   } wb_payload_t;

endpackage

// ==== design/rv_consts.svh ====
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// datapath and register file geometry.
`define XLEN        64
`define INSN_W      32
`define REG_AW      5
`define NUM_REGS    32

// major opcodes of the RV64I base set that this slice executes.
`define OPC_LUI     7'b0110111
`define OPC_AUIPC   7'b0010111
`define OPC_JAL     7'b1101111
`define OPC_JALR    7'b1100111
`define OPC_BRANCH  7'b1100011
`define OPC_LOAD    7'b0000011
`define OPC_STORE   7'b0100011
`define OPC_OPIMM   7'b0010011
`define OPC_OP      7'b0110011
`define OPC_OPIMM32 7'b0011011
`define OPC_OP32    7'b0111011

// funct7 of SUB, SRA and SRAI.
`define F7_ALT      7'b0100000

`endif
